//--- soc_fabric.f
source/soc_pkg.sv
source/dbus_ram.sv
source/gpio_port.sv
source/uart_tx.sv
source/spi_flash_reader.sv
source/ibus_arbiter.sv
source/flash_window.sv
source/soc_top.sv
testbench/tb_clock.sv
testbench/spi_flash_model.sv
testbench/soc_tb_props.sv
testbench/soc_tb.sv

//--- source/dbus_ram.sv
`timescale 1ns/10ps

module dbus_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic               ck,
    input  logic               reset_loop,
    input  soc_pkg::dbus_req_t i_req,
    output soc_pkg::dbus_rsp_t o_rsp
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [31:0]   rd_q;
    logic          ack_q;
    logic          served_q;
    logic          hit;
    logic          accept;
    logic [AW-1:0] idx;

    // Bottom quarter of the address map
    assign hit    = i_req.cyc && (i_req.adr[31:30] == 2'b00);
    assign accept = hit && !served_q;
    assign idx    = i_req.adr[AW+1:2];

    // One ack per cycle of cyc
    always_ff @(posedge ck) begin
        if (reset_loop) begin
            ack_q    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack_q    <= accept;
            served_q <= i_req.cyc && (served_q || accept);
        end
    end

    always_ff @(posedge ck) begin
        if (accept) begin
            rd_q <= mem[idx];
            if (i_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_req.sel[b]) begin
                        mem[idx][8*b +: 8] <= i_req.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign o_rsp.rdt = ack_q ? rd_q : 32'h0;
    assign o_rsp.ack = ack_q;

endmodule

//--- source/flash_window.sv
`timescale 1ns/10ps

module flash_window (
    input  logic               ck,
    input  logic               reset_loop,
    input  soc_pkg::dbus_req_t i_req,
    output soc_pkg::dbus_rsp_t o_rsp,
    output soc_pkg::ibus_req_t o_ibus,
    input  soc_pkg::ibus_rsp_t i_ibus
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_FETCH,
        W_HOLD
    } win_state_t;

    win_state_t  state_q;
    logic        ack_q;
    logic        fetch_q;
    logic [31:0] adr_q;
    logic [31:0] rd_q;
    logic        hit;

    assign hit = i_req.cyc && (i_req.adr[31:24] == FLASH_PAGE);

    always_ff @(posedge ck) begin
        if (reset_loop) begin
            state_q <= W_IDLE;
            ack_q   <= 1'b0;
            fetch_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state_q)
                W_IDLE: begin
                    if (hit && i_req.we) begin
                        // Flash is read only here, writes just complete
                        ack_q   <= 1'b1;
                        state_q <= W_HOLD;
                    end else if (hit) begin
                        fetch_q <= 1'b1;
                        state_q <= W_FETCH;
                    end
                end
                W_FETCH: begin
                    if (i_ibus.ack) begin
                        fetch_q <= 1'b0;
                        ack_q   <= 1'b1;
                        state_q <= W_HOLD;
                    end
                end
                W_HOLD: begin
                    if (!i_req.cyc) begin
                        state_q <= W_IDLE;
                    end
                end
                default: state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (state_q == W_IDLE && hit) begin
            adr_q <= i_req.adr;
            rd_q  <= 32'h0;
        end else if (state_q == W_FETCH && i_ibus.ack) begin
            rd_q <= i_ibus.rdt;
        end
    end

    assign o_ibus.adr = adr_q;
    assign o_ibus.cyc = fetch_q;
    assign o_rsp.rdt  = ack_q ? rd_q : 32'h0;
    assign o_rsp.ack  = ack_q;

endmodule

//--- source/gpio_port.sv
`timescale 1ns/10ps

module gpio_port (
    input  logic               ck,
    input  logic               reset_loop,
    input  soc_pkg::dbus_req_t i_req,
    output soc_pkg::dbus_rsp_t o_rsp,
    output logic [7:0]         o_gpio
);

    import soc_pkg::*;

    logic [7:0] gpio_q;
    logic       ack_q;
    logic       served_q;
    logic       hit;
    logic       accept;

    assign hit    = i_req.cyc && (i_req.adr[31:24] == GPIO_PAGE);
    assign accept = hit && !served_q;

    always_ff @(posedge ck) begin
        if (reset_loop) begin
            gpio_q   <= 8'h00;
            ack_q    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack_q    <= accept;
            served_q <= i_req.cyc && (served_q || accept);
            // Only lane 0 is wired
            if (accept && i_req.we && i_req.sel[0]) begin
                gpio_q <= i_req.dat[7:0];
            end
        end
    end

    assign o_rsp.rdt = ack_q ? {24'h0, gpio_q} : 32'h0;
    assign o_rsp.ack = ack_q;
    assign o_gpio    = gpio_q;

endmodule

//--- source/ibus_arbiter.sv
`timescale 1ns/10ps

module ibus_arbiter (
    input  logic               ck,
    input  logic               reset_loop,
    input  soc_pkg::ibus_req_t i_core,
    output soc_pkg::ibus_rsp_t o_core,
    input  soc_pkg::ibus_req_t i_window,
    output soc_pkg::ibus_rsp_t o_window,
    output soc_pkg::ibus_req_t o_flash_req,
    input  soc_pkg::ibus_rsp_t i_flash_rsp
);

    import soc_pkg::*;

    ibus_req_t granted;
    logic      lock_q;
    logic      owner_q;
    logic      grant_win;

    // Core wins when unlocked; a locked grant stays with its owner
    assign grant_win   = lock_q ? owner_q : !i_core.cyc;
    assign granted     = grant_win ? i_window : i_core;
    assign o_flash_req = granted;

    always_comb begin
        o_core   = '0;
        o_window = '0;
        if (grant_win) begin
            o_window = i_flash_rsp;
        end else begin
            o_core = i_flash_rsp;
        end
    end

    // Released once the owner drops cyc after its ack
    always_ff @(posedge ck) begin
        if (reset_loop) begin
            lock_q  <= 1'b0;
            owner_q <= 1'b0;
        end else if (!lock_q) begin
            if (granted.cyc) begin
                lock_q  <= 1'b1;
                owner_q <= grant_win;
            end
        end else if (!granted.cyc) begin
            lock_q <= 1'b0;
        end
    end

endmodule

//--- source/soc_pkg.sv
package soc_pkg;

    // Data bus request, as driven by the core
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
    } dbus_req_t;

    // Data bus response, OR-combined at the top level
    typedef struct packed {
        logic [31:0] rdt;
        logic        ack;
    } dbus_rsp_t;

    // Instruction bus request, read only
    typedef struct packed {
        logic [31:0] adr;
        logic        cyc;
    } ibus_req_t;

    typedef struct packed {
        logic [31:0] rdt;
        logic        ack;
    } ibus_rsp_t;

    // Serial flash outputs
    typedef struct packed {
        logic sck;
        logic csb;
        logic mosi;
    } spi_pins_t;

    // Peripheral pages, matched against adr[31:24]
    localparam logic [7:0] GPIO_PAGE  = 8'h40;
    localparam logic [7:0] UART_PAGE  = 8'h60;
    localparam logic [7:0] FLASH_PAGE = 8'h70;

    // Plain serial read opcode
    localparam logic [7:0] FLASH_READ_CMD = 8'h03;

endpackage

//--- source/soc_top.sv
`timescale 1ns/10ps

module soc_top #(
    parameter int BAUD_DIVIDE = 8,
    parameter int RAM_WORDS   = 256
) (
    input  logic               ck,
    input  logic               reset_loop,
    input  soc_pkg::ibus_req_t i_ibus,
    output soc_pkg::ibus_rsp_t o_ibus,
    input  soc_pkg::dbus_req_t i_dbus,
    output soc_pkg::dbus_rsp_t o_dbus,
    output logic               o_tx,
    output logic [7:0]         o_gpio,
    output soc_pkg::spi_pins_t o_flash,
    input  logic               i_flash_miso
);

    import soc_pkg::*;

    dbus_rsp_t ram_rsp;
    dbus_rsp_t gpio_rsp;
    dbus_rsp_t uart_rsp;
    dbus_rsp_t win_rsp;

    ibus_req_t win_ibus_req;
    ibus_rsp_t win_ibus_rsp;
    ibus_req_t flash_req;
    ibus_rsp_t flash_rsp;

    dbus_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .ck         (ck),
        .reset_loop (reset_loop),
        .i_req      (i_dbus),
        .o_rsp      (ram_rsp)
    );

    gpio_port u_gpio (
        .ck         (ck),
        .reset_loop (reset_loop),
        .i_req      (i_dbus),
        .o_rsp      (gpio_rsp),
        .o_gpio     (o_gpio)
    );

    uart_tx #(.BAUD_DIVIDE(BAUD_DIVIDE)) u_uart (
        .ck         (ck),
        .reset_loop (reset_loop),
        .i_req      (i_dbus),
        .o_rsp      (uart_rsp),
        .o_tx       (o_tx)
    );

    // Flash page reads go out over the ibus
    flash_window u_window (
        .ck         (ck),
        .reset_loop (reset_loop),
        .i_req      (i_dbus),
        .o_rsp      (win_rsp),
        .o_ibus     (win_ibus_req),
        .i_ibus     (win_ibus_rsp)
    );

    // Core has priority over the window
    ibus_arbiter u_arb (
        .ck          (ck),
        .reset_loop  (reset_loop),
        .i_core      (i_ibus),
        .o_core      (o_ibus),
        .i_window    (win_ibus_req),
        .o_window    (win_ibus_rsp),
        .o_flash_req (flash_req),
        .i_flash_rsp (flash_rsp)
    );

    spi_flash_reader u_flash (
        .ck         (ck),
        .reset_loop (reset_loop),
        .i_req      (flash_req),
        .o_rsp      (flash_rsp),
        .o_spi      (o_flash),
        .i_miso     (i_flash_miso)
    );

    // Idle responders return zero, so a plain OR merges them
    assign o_dbus = ram_rsp | gpio_rsp | uart_rsp | win_rsp;

endmodule

//--- source/spi_flash_reader.sv
`timescale 1ns/10ps

module spi_flash_reader (
    input  logic               ck,
    input  logic               reset_loop,
    input  soc_pkg::ibus_req_t i_req,
    output soc_pkg::ibus_rsp_t o_rsp,
    output soc_pkg::spi_pins_t o_spi,
    input  logic               i_miso
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_HOLD
    } spi_state_t;

    spi_state_t  state_q;
    logic        sck_q;
    logic        csb_q;
    logic        ack_q;
    logic [5:0]  bit_q;
    logic [31:0] tx_q;
    logic [31:0] rx_q;

    // 64 serial bits: command, address, then data
    always_ff @(posedge ck) begin
        if (reset_loop) begin
            state_q <= S_IDLE;
            sck_q   <= 1'b0;
            csb_q   <= 1'b1;
            ack_q   <= 1'b0;
            bit_q   <= 6'd0;
        end else begin
            ack_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (i_req.cyc) begin
                        csb_q   <= 1'b0;
                        sck_q   <= 1'b0;
                        bit_q   <= 6'd0;
                        state_q <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    sck_q <= !sck_q;
                    // High half done, sck about to fall
                    if (sck_q) begin
                        bit_q <= bit_q + 6'd1;
                        if (bit_q == 6'd63) begin
                            csb_q   <= 1'b1;
                            ack_q   <= 1'b1;
                            state_q <= S_HOLD;
                        end
                    end
                end
                S_HOLD: begin
                    // Wait for the requester to release cyc
                    if (!i_req.cyc) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (state_q == S_IDLE && i_req.cyc) begin
            tx_q <= {FLASH_READ_CMD, i_req.adr[23:0]};
        end else if (state_q == S_SHIFT) begin
            if (sck_q) begin
                // MOSI moves on falling sck
                tx_q <= {tx_q[30:0], 1'b0};
            end else if (bit_q[5]) begin
                // MISO sampled as sck rises, data phase only
                rx_q <= {rx_q[30:0], i_miso};
            end
        end
    end

    // First byte received lands in bits 7:0
    assign o_rsp.rdt = ack_q ? {rx_q[7:0], rx_q[15:8], rx_q[23:16], rx_q[31:24]} : 32'h0;
    assign o_rsp.ack = ack_q;

    assign o_spi.sck  = sck_q;
    assign o_spi.csb  = csb_q;
    assign o_spi.mosi = tx_q[31] && !csb_q;

endmodule

//--- source/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int BAUD_DIVIDE = 8
) (
    input  logic               ck,
    input  logic               reset_loop,
    input  soc_pkg::dbus_req_t i_req,
    output soc_pkg::dbus_rsp_t o_rsp,
    output logic               o_tx
);

    import soc_pkg::*;

    localparam int CW = $clog2(BAUD_DIVIDE + 1);

    logic [CW-1:0] baud_q;
    logic [9:0]    frame_q;
    logic [3:0]    bits_q;
    logic          ack_q;
    logic          served_q;
    logic          hit;
    logic          accept;
    logic          busy;
    logic          bit_end;

    assign hit     = i_req.cyc && (i_req.adr[31:24] == UART_PAGE);
    assign accept  = hit && !served_q;
    assign busy    = (bits_q != 4'd0);
    assign bit_end = (baud_q == CW'(BAUD_DIVIDE - 1));

    always_ff @(posedge ck) begin
        if (reset_loop) begin
            ack_q    <= 1'b0;
            served_q <= 1'b0;
            baud_q   <= '0;
            bits_q   <= 4'd0;
            // Line idles high
            frame_q  <= 10'h3ff;
        end else begin
            ack_q    <= accept;
            served_q <= i_req.cyc && (served_q || accept);
            if (accept && i_req.we && i_req.sel[0] && !busy) begin
                // Stop, data LSB first, start
                frame_q <= {1'b1, i_req.dat[7:0], 1'b0};
                bits_q  <= 4'd10;
                baud_q  <= '0;
            end else if (busy) begin
                if (bit_end) begin
                    baud_q  <= '0;
                    frame_q <= {1'b1, frame_q[9:1]};
                    bits_q  <= bits_q - 4'd1;
                end else begin
                    baud_q <= baud_q + 1'b1;
                end
            end
        end
    end

    // Status read, busy in bit 0
    assign o_rsp.rdt = ack_q ? {31'h0, busy} : 32'h0;
    assign o_rsp.ack = ack_q;
    assign o_tx      = frame_q[0];

endmodule

//--- testbench/soc_tb.sv
`timescale 1ns/10ps

module soc_tb;

    import soc_pkg::*;

    localparam int BAUD_DIVIDE = 8;
    localparam int RAM_WORDS   = 256;
    localparam int WAIT_LIMIT  = 600;

    typedef struct packed {
        logic [31:0] got;
        logic [31:0] exp;
    } result_t;

    logic       ck;
    logic       reset_loop;
    ibus_req_t  ibus_req;
    ibus_rsp_t  ibus_rsp;
    dbus_req_t  dbus_req;
    dbus_rsp_t  dbus_rsp;
    logic       tx;
    logic [7:0] gpio;
    spi_pins_t  flash_pins;
    logic       flash_miso;

    result_t     result_q[$];
    string       label_q[$];
    logic [31:0] shadow[16];
    integer      seed;
    int          checked = 0;
    int          errors  = 0;

    tb_clock u_clock (
        .o_ck (ck)
    );

    spi_flash_model u_flash_model (
        .i_sck  (flash_pins.sck),
        .i_csb  (flash_pins.csb),
        .i_mosi (flash_pins.mosi),
        .o_miso (flash_miso)
    );

    soc_top #(
        .BAUD_DIVIDE (BAUD_DIVIDE),
        .RAM_WORDS   (RAM_WORDS)
    ) uut (
        .ck           (ck),
        .reset_loop   (reset_loop),
        .i_ibus       (ibus_req),
        .o_ibus       (ibus_rsp),
        .i_dbus       (dbus_req),
        .o_dbus       (dbus_rsp),
        .o_tx         (tx),
        .o_gpio       (gpio),
        .o_flash      (flash_pins),
        .i_flash_miso (flash_miso)
    );

    // Flash byte at address a is a[7:0] ^ 5a, lowest address in bits 7:0
    function automatic logic [31:0] flash_word(logic [23:0] a);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = (a[7:0] + 8'(k)) ^ 8'h5a;
        end
        return w;
    endfunction

    function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] dat,
                                                logic [3:0] sel);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                w[8*b +: 8] = dat[8*b +: 8];
            end
        end
        return w;
    endfunction

    // Start bit, data LSB first, stop bit
    function automatic logic uart_bit(logic [7:0] data, int n);
        if (n == 0) begin
            return 1'b0;
        end
        if (n == 9) begin
            return 1'b1;
        end
        return data[n-1];
    endfunction

    function automatic void post_result(string label, logic [31:0] got, logic [31:0] exp);
        result_q.push_back('{got: got, exp: exp});
        label_q.push_back(label);
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic dbus_cycle(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, input logic we,
                              output logic [31:0] rdt);
        int waited;
        @(negedge ck);
        dbus_req = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1};
        waited = 0;
        @(negedge ck);
        while (!dbus_rsp.ack) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout waiting for dbus ack at address %h", adr);
                abort_run();
            end
            @(negedge ck);
        end
        rdt = dbus_rsp.rdt;
        @(negedge ck);
        dbus_req = '0;
    endtask

    task automatic ibus_fetch(input logic [31:0] adr, output logic [31:0] rdt);
        int waited;
        @(negedge ck);
        ibus_req = '{adr: adr, cyc: 1'b1};
        waited = 0;
        @(negedge ck);
        while (!ibus_rsp.ack) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout waiting for ibus ack at address %h", adr);
                abort_run();
            end
            @(negedge ck);
        end
        rdt = ibus_rsp.rdt;
        @(negedge ck);
        ibus_req = '0;
    endtask

    // Samples the middle of each bit of one frame
    task automatic watch_frame(input logic [7:0] data);
        int waited;
        waited = 0;
        @(negedge ck);
        while (tx !== 1'b0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout waiting for the UART start bit");
                abort_run();
            end
            @(negedge ck);
        end
        repeat (BAUD_DIVIDE / 2) @(negedge ck);
        for (int n = 0; n < 10; n++) begin
            post_result($sformatf("uart bit %0d", n), {31'h0, tx}, {31'h0, uart_bit(data, n)});
            repeat (BAUD_DIVIDE) @(negedge ck);
        end
    endtask

    // Comparing process
    always @(posedge ck) begin
        result_t r;
        string   label;
        assert (uut.u_props.violation_count == 0) else begin
            $display("A bus protocol assertion fired in soc_tb_props");
            abort_run();
        end
        while (result_q.size() > 0) begin
            r     = result_q.pop_front();
            label = label_q.pop_front();
            checked++;
            assert (r.got === r.exp) else begin
                errors++;
                $display("ERR %0t: %s got %h expected %h", $time, label, r.got, r.exp);
                abort_run();
            end
        end
    end

    initial begin
        logic [31:0] rdt;
        logic [31:0] word;
        logic [31:0] core_rdt;
        logic [31:0] win_rdt;
        logic [23:0] fadr;
        logic [23:0] wadr;
        logic [3:0]  sel;
        int          idx;
        int          waited;
        time         core_done;
        time         win_done;

        seed       = 32'hdef0_b6ae;
        reset_loop = 1'b1;
        ibus_req   = '0;
        dbus_req   = '0;
        repeat (3) @(negedge ck);
        reset_loop = 1'b0;

        @(negedge ck);
        post_result("tx idle", {31'h0, tx}, 32'h1);
        post_result("gpio reset", {24'h0, gpio}, 32'h0);
        post_result("csb idle", {31'h0, flash_pins.csb}, 32'h1);
        post_result("sck idle", {31'h0, flash_pins.sck}, 32'h0);
        post_result("acks idle", {30'h0, dbus_rsp.ack, ibus_rsp.ack}, 32'h0);

        // Full words first so every lane is known
        for (int i = 0; i < 16; i++) begin
            word = $random(seed);
            dbus_cycle(32'(i * 4), word, 4'hf, 1'b1, rdt);
            shadow[i] = word;
        end
        for (int n = 0; n < 40; n++) begin
            idx  = $random(seed) & 32'hf;
            word = $random(seed);
            sel  = 4'($random(seed));
            dbus_cycle(32'(idx * 4), word, sel, 1'b1, rdt);
            shadow[idx] = merge_lanes(shadow[idx], word, sel);
        end
        for (int i = 0; i < 16; i++) begin
            dbus_cycle(32'(i * 4), 32'h0, 4'hf, 1'b0, rdt);
            post_result($sformatf("ram word %0d", i), rdt, shadow[i]);
        end

        word = $random(seed);
        dbus_cycle({GPIO_PAGE, 24'h0}, word, 4'h1, 1'b1, rdt);
        post_result("gpio pins", {24'h0, gpio}, {24'h0, word[7:0]});
        dbus_cycle({GPIO_PAGE, 24'h0}, 32'h0, 4'hf, 1'b0, rdt);
        post_result("gpio read", rdt, {24'h0, word[7:0]});

        // Second write lands while busy and must not disturb the frame
        word = $random(seed);
        fork
            watch_frame(word[7:0]);
            begin
                dbus_cycle({UART_PAGE, 24'h0}, word, 4'h1, 1'b1, rdt);
                dbus_cycle({UART_PAGE, 24'h0}, 32'h0, 4'hf, 1'b0, rdt);
                post_result("uart busy", rdt, 32'h1);
                dbus_cycle({UART_PAGE, 24'h0}, ~word, 4'h1, 1'b1, rdt);
            end
        join
        dbus_cycle({UART_PAGE, 24'h0}, 32'h0, 4'hf, 1'b0, rdt);
        post_result("uart idle", rdt, 32'h0);

        word = $random(seed);
        fadr = word[23:0];
        ibus_fetch({8'h00, fadr}, rdt);
        post_result("core fetch", rdt, flash_word(fadr));
        word = $random(seed);
        wadr = word[23:0];
        dbus_cycle({FLASH_PAGE, wadr}, 32'h0, 4'hf, 1'b0, rdt);
        post_result("window read", rdt, flash_word(wadr));

        // Core and window at once
        word = $random(seed);
        fadr = word[23:0];
        word = $random(seed);
        wadr = word[23:0];
        fork
            begin
                // Window adds a cycle, so both reach the arbiter together
                @(negedge ck);
                ibus_fetch({8'h00, fadr}, core_rdt);
                core_done = $time;
            end
            begin
                dbus_cycle({FLASH_PAGE, wadr}, 32'h0, 4'hf, 1'b0, win_rdt);
                win_done = $time;
            end
        join
        post_result("shared core fetch", core_rdt, flash_word(fadr));
        post_result("shared window read", win_rdt, flash_word(wadr));
        post_result("core served first", {31'h0, core_done < win_done}, 32'h1);

        waited = 0;
        @(negedge ck);
        while (result_q.size() != 0) begin
            waited++;
            if (waited > 10) begin
                $display("Timeout waiting for the checker to drain its queue");
                abort_run();
            end
            @(negedge ck);
        end
        @(negedge ck);
        if (errors == 0 && uut.u_props.violation_count == 0) begin
            $display("Checked %0d results", checked);
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("%0d checks failed, %0d bus protocol assertions fired",
                     errors, uut.u_props.violation_count);
            abort_run();
        end
    end

endmodule

//--- testbench/soc_tb_props.sv
`timescale 1ns/10ps

module soc_tb_props (
    input logic               ck,
    input logic               reset_loop,
    input soc_pkg::ibus_req_t i_core_req,
    input soc_pkg::ibus_rsp_t i_core_rsp,
    input soc_pkg::dbus_req_t i_dbus_req,
    input soc_pkg::dbus_rsp_t i_dbus_rsp,
    input soc_pkg::ibus_req_t i_flash_req,
    input soc_pkg::ibus_rsp_t i_flash_rsp,
    input soc_pkg::spi_pins_t i_spi,
    input logic [3:0]         i_dbus_acks
);

    int violation_count = 0;

    // An ack always answers a live cycle
    dbus_ack_live: assert property (@(posedge ck) disable iff (reset_loop)
        i_dbus_rsp.ack |-> i_dbus_req.cyc)
    else begin
        $error("dbus ack without cyc");
        violation_count++;
    end

    core_ack_live: assert property (@(posedge ck) disable iff (reset_loop)
        i_core_rsp.ack |-> i_core_req.cyc)
    else begin
        $error("core ibus ack without cyc");
        violation_count++;
    end

    flash_ack_live: assert property (@(posedge ck) disable iff (reset_loop)
        i_flash_rsp.ack |-> i_flash_req.cyc)
    else begin
        $error("flash ibus ack without cyc");
        violation_count++;
    end

    // Clock parked low while deselected
    sck_idle_low: assert property (@(posedge ck) disable iff (reset_loop)
        i_spi.csb |-> !i_spi.sck)
    else begin
        $error("sck high while csb is high");
        violation_count++;
    end

    single_responder: assert property (@(posedge ck) disable iff (reset_loop)
        $onehot0(i_dbus_acks))
    else begin
        $error("more than one dbus responder acked");
        violation_count++;
    end

endmodule

bind soc_top soc_tb_props u_props (
    .ck          (ck),
    .reset_loop  (reset_loop),
    .i_core_req  (i_ibus),
    .i_core_rsp  (o_ibus),
    .i_dbus_req  (i_dbus),
    .i_dbus_rsp  (o_dbus),
    .i_flash_req (flash_req),
    .i_flash_rsp (flash_rsp),
    .i_spi       (o_flash),
    .i_dbus_acks ({ram_rsp.ack, gpio_rsp.ack, uart_rsp.ack, win_rsp.ack})
);

//--- testbench/spi_flash_model.sv
`timescale 1ns/10ps

module spi_flash_model (
    input  logic i_sck,
    input  logic i_csb,
    input  logic i_mosi,
    output logic o_miso
);

    logic [31:0] shift_in;
    logic [7:0]  data_byte;
    int          edges;
    int          stream;

    initial begin
        o_miso   = 1'b0;
        shift_in = '0;
        edges    = 0;
    end

    // Every select starts a new command
    always @(negedge i_csb) begin
        edges = 0;
    end

    // Opcode and address clocked in on rising sck
    always @(posedge i_sck) begin
        if (!i_csb) begin
            if (edges < 32) begin
                shift_in = {shift_in[30:0], i_mosi};
            end
            edges = edges + 1;
        end
    end

    // Data out on falling sck, address counts up per byte
    always @(negedge i_sck) begin
        if (!i_csb && edges >= 32) begin
            stream    = edges - 32;
            data_byte = (shift_in[7:0] + 8'(stream / 8)) ^ 8'h5a;
            // Unknown opcode gives garbage data
            o_miso = (shift_in[31:24] == 8'h03) ? data_byte[7 - (stream % 8)] : 1'bx;
        end
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD = 10
) (
    output logic o_ck
);

    // 20 ns period
    initial begin
        o_ck = 1'b0;
    end

    always #(HALF_PERIOD) o_ck = ~o_ck;

endmodule
